// File: src/drops_pkg.sv
package drops_pkg;

	// sequencer phases, EN_* raises the enable, WAIT_* holds it until done
	typedef enum logic [2:0] {
		EN_INP,
		WAIT_INP,
		EN_ACT,
		WAIT_ACT,
		EN_DISP,
		WAIT_DISP
	} phase_t;

	localparam int unsigned GS_DEF     = 8; // grid edge, GS x GS field
	localparam int unsigned CR_DEF     = 4; // action steps per fall
	localparam int unsigned CR_BUT_DEF = 4; // button samples per input phase
	localparam int unsigned N_PAT      = 10; // placement entries

	// one row per byte, byte 0 (low end) drops on the first fall
	localparam logic [N_PAT*GS_DEF-1:0] DROP_PATTERN_DEF =
		80'b01000000_00000100_00010000_00000001_10000000_00100000_00000010_00001000_10000000_00000100;

endpackage

// File: src/get_input.sv
`timescale 1ns/1ps

module get_input #(
	parameter int unsigned CR_BUT = drops_pkg::CR_BUT_DEF
) (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic e_inp_i,
	input  logic right_i,
	input  logic left_i,
	output logic right_o,
	output logic left_o,
	output logic d_inp_o
);

	localparam int unsigned CNT_W = $clog2(CR_BUT + 1);

	logic [CNT_W-1:0] cnt; // samples taken so far
	logic busy;            // window finished, wait for enable to drop
	logic held_r;          // right high on every sample so far
	logic held_l;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt     <= '0;
			busy    <= 1'b0;
			held_r  <= 1'b1;
			held_l  <= 1'b1;
			right_o <= 1'b0;
			left_o  <= 1'b0;
			d_inp_o <= 1'b0;
		end else begin
			d_inp_o <= 1'b0; // single cycle pulse
			if (!e_inp_i) begin
				// idle, rearm the window
				busy   <= 1'b0;
				cnt    <= '0;
				held_r <= 1'b1;
				held_l <= 1'b1;
			end else if (!busy) begin
				if (cnt == CNT_W'(CR_BUT - 1)) begin
					// last sample goes straight into the result
					right_o <= held_r & right_i;
					left_o  <= held_l & left_i;
					d_inp_o <= 1'b1;
					busy    <= 1'b1;
					cnt     <= '0;
					held_r  <= 1'b1;
					held_l  <= 1'b1;
				end else begin
					cnt    <= cnt + 1'b1;
					held_r <= held_r & right_i; // any low sample kills the press
					held_l <= held_l & left_i;
				end
			end
		end
	end

endmodule

// File: src/action.sv
`timescale 1ns/1ps

module action #(
	parameter int unsigned GS = drops_pkg::GS_DEF,
	parameter int unsigned CR = drops_pkg::CR_DEF,
	parameter logic [drops_pkg::N_PAT*GS-1:0] DROP_PATTERN = drops_pkg::DROP_PATTERN_DEF
) (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            e_act_i,
	input  logic            right_i,
	input  logic            left_i,
	output logic [GS*GS-1:0] matrix_o,
	output logic            d_act_o
);

	import drops_pkg::*;

	localparam int unsigned POS_W  = $clog2(GS);
	localparam int unsigned STEP_W = $clog2(CR + 1);
	localparam int unsigned IDX_W  = $clog2(N_PAT);

	logic [GS*GS-1:0]  drops;     // drop rows only, no player
	logic [GS*GS-1:0]  drops_nx;
	logic [GS*GS-1:0]  player;    // player bit in the bottom row
	logic [POS_W-1:0]  pos;       // player column
	logic [POS_W-1:0]  pos_nx;
	logic [STEP_W-1:0] step_cnt;  // steps since last fall
	logic [IDX_W-1:0]  pat_idx;   // next pattern byte
	logic [IDX_W-1:0]  idx_nx;
	logic              fall;
	logic              busy;      // step done for this enable

	always_comb begin
		// move, opposite presses cancel
		pos_nx = pos;
		if (right_i && !left_i && pos != POS_W'(GS - 1))
			pos_nx = pos + 1'b1;
		else if (left_i && !right_i && pos != '0)
			pos_nx = pos - 1'b1;

		fall     = (step_cnt == STEP_W'(CR - 1));
		drops_nx = drops;
		idx_nx   = pat_idx;
		if (fall) begin
			// rows move down, old bottom row drops off the top bits
			drops_nx = {drops[GS*GS-GS-1:0], DROP_PATTERN[pat_idx*GS +: GS]};
			idx_nx   = (pat_idx == IDX_W'(N_PAT - 1)) ? '0 : pat_idx + 1'b1;
		end

		player = '0;
		player[(GS-1)*GS + pos_nx] = 1'b1;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			drops    <= '0;
			pos      <= POS_W'(GS / 2); // start mid row
			step_cnt <= '0;
			pat_idx  <= '0;
			busy     <= 1'b0;
			matrix_o <= '0;
			d_act_o  <= 1'b0;
		end else begin
			d_act_o <= 1'b0;
			if (!e_act_i) begin
				busy <= 1'b0;
			end else if (!busy) begin
				// one game step per enable
				pos      <= pos_nx;
				drops    <= drops_nx;
				pat_idx  <= idx_nx;
				step_cnt <= fall ? '0 : step_cnt + 1'b1;
				matrix_o <= drops_nx | player; // field visible to display
				d_act_o  <= 1'b1;
				busy     <= 1'b1;
			end
		end
	end

endmodule

// File: src/display.sv
`timescale 1ns/1ps

module display #(
	parameter int unsigned GS = drops_pkg::GS_DEF
) (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  logic             e_disp_i,
	input  logic [GS*GS-1:0] matrix_i,
	output logic [GS-1:0]    row_val_o,
	output logic [GS-1:0]    col_val_o,
	output logic             d_disp_o
);

	localparam int unsigned ROW_W = $clog2(GS);

	logic [ROW_W-1:0] row_cnt; // row being driven
	logic busy;                // frame scanned, wait for enable low

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			row_cnt   <= '0;
			busy      <= 1'b0;
			row_val_o <= '0;
			col_val_o <= '0;
			d_disp_o  <= 1'b0;
		end else begin
			// dark unless a row is scanned this cycle
			row_val_o <= '0;
			col_val_o <= '0;
			d_disp_o  <= 1'b0;
			if (!e_disp_i) begin
				busy    <= 1'b0;
				row_cnt <= '0;
			end else if (!busy) begin
				row_val_o <= GS'(1) << row_cnt;         // one hot select
				col_val_o <= matrix_i[row_cnt*GS +: GS]; // that row's columns
				if (row_cnt == ROW_W'(GS - 1)) begin
					d_disp_o <= 1'b1; // done with last row
					busy     <= 1'b1;
					row_cnt  <= '0;
				end else begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: src/phase_sequencer.sv
`timescale 1ns/1ps

module phase_sequencer (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic ena_i,
	input  logic d_inp_i,
	input  logic d_act_i,
	input  logic d_disp_i,
	output logic e_inp_o,
	output logic e_act_o,
	output logic e_disp_o
);

	import drops_pkg::*;

	phase_t state;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state    <= EN_INP;
			e_inp_o  <= 1'b0;
			e_act_o  <= 1'b0;
			e_disp_o <= 1'b0;
		end else begin
			case (state)
				EN_INP: begin
					// new step only while the slot is enabled
					if (ena_i) begin
						e_inp_o <= 1'b1;
						state   <= WAIT_INP;
					end
				end
				WAIT_INP: begin
					if (d_inp_i) begin
						e_inp_o <= 1'b0;
						state   <= EN_ACT;
					end
				end
				EN_ACT: begin
					e_act_o <= 1'b1;
					state   <= WAIT_ACT;
				end
				WAIT_ACT: begin
					if (d_act_i) begin
						e_act_o <= 1'b0;
						state   <= EN_DISP;
					end
				end
				EN_DISP: begin
					e_disp_o <= 1'b1;
					state    <= WAIT_DISP;
				end
				WAIT_DISP: begin
					if (d_disp_i) begin
						e_disp_o <= 1'b0;
						state    <= EN_INP; // frame out, back to buttons
					end
				end
				default: begin
					// unused codes, park with everything off
					state    <= EN_INP;
					e_inp_o  <= 1'b0;
					e_act_o  <= 1'b0;
					e_disp_o <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: src/tt_um_drops.sv
`timescale 1ns/1ps

module tt_um_drops #(
	parameter int unsigned GS     = drops_pkg::GS_DEF,
	parameter int unsigned CR     = drops_pkg::CR_DEF,
	parameter int unsigned CR_BUT = drops_pkg::CR_BUT_DEF,
	parameter logic [drops_pkg::N_PAT*GS-1:0] DROP_PATTERN = drops_pkg::DROP_PATTERN_DEF
) (
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  logic       ena_i,
	input  logic [7:0] ui_in_i,   // bit 0 right, bit 1 left
	input  logic [7:0] uio_in_i,  // bidir inputs, not used
	output logic [7:0] uo_out_o,  // row select
	output logic [7:0] uio_out_o, // column bits
	output logic [7:0] uio_oe_o
);

	logic e_inp, d_inp;
	logic e_act, d_act;
	logic e_disp, d_disp;
	logic right, left;          // sampled presses
	logic [GS*GS-1:0] matrix;   // field, row r at r*GS

	assign uio_oe_o = 8'hff; // bidir pins all driven

	phase_sequencer u_seq (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.ena_i    (ena_i),
		.d_inp_i  (d_inp),
		.d_act_i  (d_act),
		.d_disp_i (d_disp),
		.e_inp_o  (e_inp),
		.e_act_o  (e_act),
		.e_disp_o (e_disp)
	);

	get_input #(
		.CR_BUT (CR_BUT)
	) u_get_input (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.e_inp_i  (e_inp),
		.right_i  (ui_in_i[0]),
		.left_i   (ui_in_i[1]),
		.right_o  (right),
		.left_o   (left),
		.d_inp_o  (d_inp)
	);

	action #(
		.GS           (GS),
		.CR           (CR),
		.DROP_PATTERN (DROP_PATTERN)
	) u_action (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.e_act_i  (e_act),
		.right_i  (right),
		.left_i   (left),
		.matrix_o (matrix),
		.d_act_o  (d_act)
	);

	display #(
		.GS (GS)
	) u_display (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.e_disp_i  (e_disp),
		.matrix_i  (matrix),
		.row_val_o (uo_out_o),
		.col_val_o (uio_out_o),
		.d_disp_o  (d_disp)
	);

endmodule

// File: sim/drops_asserts.sv
`timescale 1ns/1ps

module drops_asserts (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic e_inp_i,
	input  logic e_act_i,
	input  logic e_disp_i,
	input  logic d_inp_i,
	input  logic d_act_i,
	input  logic d_disp_i
);

	int fail_cnt = 0; // read by the testbench at the end

	// one phase at a time
	a_one_enable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0({e_inp_i, e_act_i, e_disp_i}))
		else begin
			$error("more than one phase enable high");
			fail_cnt++;
		end

	// enable drops right after its done pulse
	a_inp_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		d_inp_i |=> !e_inp_i)
		else begin
			$error("input enable still high after done");
			fail_cnt++;
		end
	a_act_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		d_act_i |=> !e_act_i)
		else begin
			$error("action enable still high after done");
			fail_cnt++;
		end
	a_disp_drop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		d_disp_i |=> !e_disp_i)
		else begin
			$error("display enable still high after done");
			fail_cnt++;
		end

	// done only answers a live enable
	a_done_en: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(!d_inp_i || e_inp_i) && (!d_act_i || e_act_i) && (!d_disp_i || e_disp_i))
		else begin
			$error("done pulse without its enable");
			fail_cnt++;
		end

endmodule

bind phase_sequencer drops_asserts u_asserts (
	.clk_i    (clk_i),
	.arst_n_i (arst_n_i),
	.e_inp_i  (e_inp_o),
	.e_act_i  (e_act_o),
	.e_disp_i (e_disp_o),
	.d_inp_i  (d_inp_i),
	.d_act_i  (d_act_i),
	.d_disp_i (d_disp_i)
);

// File: sim/tb_drops.sv
`timescale 1ns/1ps

module tb_drops;

	import drops_pkg::*;

	localparam int CLK_PER = 100;
	localparam int N_MOVE  = 20;
	localparam int N_FALL  = 44; // enough for ten falls plus a wrap
	localparam int N_SCAN  = 8;
	localparam int N_GATE  = 4;
	localparam int N_RAND  = 200;
	localparam int MAX_GAP = 16; // longest random ena_i drop in cycles
	localparam int FRAMES  = 1 + N_MOVE + N_FALL + N_SCAN + N_GATE + N_RAND;
	localparam int GAP_CYC = 2 * 50 + N_RAND * MAX_GAP;
	localparam int WD_FRAMES = FRAMES + GAP_CYC / 40 + 1; // gaps counted as frames

	logic       clk;
	logic       arst_n_i;
	logic       ena_i;
	logic [7:0] ui_in_i;
	logic [7:0] uio_in_i;
	logic [7:0] uo_out_o;
	logic [7:0] uio_out_o;
	logic [7:0] uio_oe_o;

	logic [GS_DEF-1:0] frame [0:GS_DEF-1]; // captured columns per row
	logic [GS_DEF-1:0] mrows [0:GS_DEF-1]; // model drop rows
	int mpos;       // model player column
	int mstep;      // model steps since last fall
	int midx;       // model next pattern byte
	int fall_total;
	bit mfell;      // last step had a fall
	int loaded_idx; // byte loaded on that fall

	int err_cnt  = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int mark;       // err_cnt when the test began
	int asrt;

	tt_um_drops DUT (
		.clk_i     (clk),
		.arst_n_i  (arst_n_i),
		.ena_i     (ena_i),
		.ui_in_i   (ui_in_i),
		.uio_in_i  (uio_in_i),
		.uo_out_o  (uo_out_o),
		.uio_out_o (uio_out_o),
		.uio_oe_o  (uio_oe_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PER / 2) clk = ~clk;
	end

	// stuck sequencer guard
	initial begin
		#(WD_FRAMES * 40 * CLK_PER);
		$display("timeout, display stopped scanning rows");
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic model_reset();
		for (int r = 0; r < GS_DEF; r++)
			mrows[r] = '0;
		mpos       = GS_DEF / 2;
		mstep      = 0;
		midx       = 0;
		fall_total = 0;
		mfell      = 1'b0;
	endtask

	// one game step from the rules
	task automatic model_step(input bit rt, input bit lf);
		if (rt && !lf && mpos < GS_DEF - 1)
			mpos++;
		else if (lf && !rt && mpos > 0)
			mpos--;
		mfell = 1'b0;
		mstep++;
		if (mstep == CR_DEF) begin
			mstep = 0;
			for (int r = GS_DEF - 1; r > 0; r--)
				mrows[r] = mrows[r-1]; // bottom row falls off
			mrows[0]   = DROP_PATTERN_DEF[midx*GS_DEF +: GS_DEF];
			loaded_idx = midx;
			midx       = (midx + 1) % N_PAT;
			mfell      = 1'b1;
			fall_total++;
		end
	endtask

	function automatic logic [GS_DEF-1:0] model_row(input int r);
		logic [GS_DEF-1:0] v;
		v = mrows[r];
		if (r == GS_DEF - 1)
			v[mpos] = 1'b1; // player on bottom row
		return v;
	endfunction

	// rows 0 to 7 once and in order
	task automatic capture_frame();
		int r;
		r = 0;
		while (r < GS_DEF) begin
			@(posedge clk);
			if (uo_out_o != 8'h00) begin
				if (uo_out_o !== (8'h01 << r)) begin
					$display("ERR uo_out_o row %0d exp %h got %h", r, 8'h01 << r, uo_out_o);
					err_cnt++;
				end
				frame[r] = uio_out_o;
				r++;
			end else if (uio_out_o !== 8'h00) begin
				$display("ERR uio_out_o idle exp 00 got %h", uio_out_o); // dark between frames
				err_cnt++;
			end
		end
	endtask

	// starts on a falling edge and returns on the one after row 7
	task automatic run_frame(input bit rt, input bit lf);
		logic [GS_DEF-1:0] exp_row;
		ui_in_i = {6'b0, lf, rt};
		ena_i   = 1'b1;
		model_step(rt, lf);
		capture_frame();
		for (int r = 0; r < GS_DEF; r++) begin
			exp_row = model_row(r);
			if (frame[r] !== exp_row) begin
				$display("ERR uio_out_o row %0d exp %h got %h", r, exp_row, frame[r]);
				err_cnt++;
			end
		end
		if (uio_oe_o !== 8'hff) begin
			$display("ERR uio_oe_o exp ff got %h", uio_oe_o);
			err_cnt++;
		end
		@(negedge clk);
	endtask

	// no rows may show while ena_i is low
	task automatic gate_cycles(input int n);
		ena_i = 1'b0;
		repeat (n) begin
			@(posedge clk);
			if (uo_out_o !== 8'h00) begin
				$display("ERR uo_out_o gated exp 00 got %h", uo_out_o);
				err_cnt++;
			end
		end
		@(negedge clk);
	endtask

	task automatic row7_is(input logic [7:0] v, input string what);
		if (frame[GS_DEF-1] !== v) begin
			$display("ERR uio_out_o row 7 %s exp %h got %h", what, v, frame[GS_DEF-1]);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == mark) begin
			pass_cnt++;
			$display("pass  %s", name);
		end else begin
			fail_cnt++;
			$display("fail  %s (%0d errors)", name, err_cnt - mark);
		end
		mark = err_cnt;
	endtask

	initial begin
		bit rt;
		bit lf;
		bit wrap_seen;
		void'($urandom(93));
		arst_n_i = 1'b0;
		ena_i    = 1'b1;
		ui_in_i  = 8'h00;
		uio_in_i = 8'h00;
		mark     = 0;
		model_reset();

		// reset state and first frame
		repeat (3) @(posedge clk);
		if (uo_out_o !== 8'h00 || uio_out_o !== 8'h00) begin
			$display("ERR uo_out_o/uio_out_o in reset exp 00 got %h %h", uo_out_o, uio_out_o);
			err_cnt++;
		end
		if (uio_oe_o !== 8'hff) begin
			$display("ERR uio_oe_o exp ff got %h", uio_oe_o);
			err_cnt++;
		end
		@(negedge clk);
		arst_n_i = 1'b1;
		run_frame(1'b0, 1'b0);
		for (int r = 0; r < GS_DEF - 1; r++) begin
			if (frame[r] !== 8'h00) begin
				$display("ERR uio_out_o row %0d exp 00 got %h", r, frame[r]);
				err_cnt++;
			end
		end
		row7_is(8'h10, "first frame");
		finish_test("after reset");

		// moves and saturation while no drop reaches row 7
		repeat (6) run_frame(1'b1, 1'b0);
		row7_is(8'h80, "right edge");
		repeat (10) run_frame(1'b0, 1'b1);
		row7_is(8'h01, "left edge");
		run_frame(1'b1, 1'b0);
		row7_is(8'h02, "one right");
		repeat (2) run_frame(1'b1, 1'b1); // both cancel
		row7_is(8'h02, "both pressed");
		run_frame(1'b0, 1'b0);
		row7_is(8'h02, "no move");
		finish_test("movement");

		// falls every 4th step and the pattern wraps
		wrap_seen = 1'b0;
		for (int i = 0; i < N_FALL; i++) begin
			run_frame(1'b0, 1'b0);
			if (mfell && loaded_idx == 0 && fall_total > 1) begin
				wrap_seen = 1'b1;
				if (frame[0] !== DROP_PATTERN_DEF[GS_DEF-1:0]) begin
					$display("ERR uio_out_o row 0 wrap exp %h got %h",
						DROP_PATTERN_DEF[GS_DEF-1:0], frame[0]);
					err_cnt++;
				end
			end
		end
		if (!wrap_seen) begin
			$display("pattern never came back to its first byte");
			err_cnt++;
		end
		finish_test("falling drops");

		// row order is checked inside every capture
		for (int i = 0; i < N_SCAN; i++)
			run_frame(i[0], i[1]);
		finish_test("row scan");

		// ena_i low freezes the game
		gate_cycles(50);
		run_frame(1'b0, 1'b0);
		run_frame(1'b1, 1'b0);
		gate_cycles(50);
		run_frame(1'b0, 1'b1);
		run_frame(1'b0, 1'b0);
		finish_test("enable gating");

		// random buttons with short ena_i drops
		for (int i = 0; i < N_RAND; i++) begin
			if ($urandom_range(7, 0) == 0)
				gate_cycles($urandom_range(MAX_GAP, 1));
			rt = $urandom_range(1, 0);
			lf = $urandom_range(1, 0);
			run_frame(rt, lf);
		end
		finish_test("random run");

		asrt = DUT.u_seq.u_asserts.fail_cnt;
		if (asrt != 0) begin
			$display("sequencer assertions failed %0d times", asrt);
			fail_cnt++;
		end
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
src/drops_pkg.sv
src/get_input.sv
src/action.sv
src/display.sv
src/phase_sequencer.sv
src/tt_um_drops.sv
sim/drops_asserts.sv
sim/tb_drops.sv
